//--- hw/arcade_pkg.sv
/*
 * Shared constants and types for the arcade board glue.
 * Imported by every module that needs game codes, widths or the picture word.
 */

package arcade_pkg;

	// ======================================================================
	// Joystick word
	// ======================================================================
	localparam int JOY_W      = 12;
	localparam int JOY_RIGHT  = 0;
	localparam int JOY_LEFT   = 1;
	localparam int JOY_DOWN   = 2;
	localparam int JOY_UP     = 3;
	localparam int JOY_FIRE_A = 4;
	localparam int JOY_FIRE_B = 5;
	localparam int JOY_FIRE_C = 6;
	localparam int JOY_START1 = 8;
	localparam int JOY_START2 = 9;
	localparam int JOY_COIN   = 10;

	// Game identifiers as sent in the IDX_GAME stream
	localparam logic [7:0] GAME_SCRAMBLE = 8'd0;
	localparam logic [7:0] GAME_TAZMAN   = 8'd4;
	localparam logic [7:0] GAME_SPDCOIN  = 8'd7;
	localparam logic [7:0] GAME_STRATGYX = 8'd14;

	// Download stream selectors
	localparam logic [7:0] IDX_GAME    = 8'd1;
	localparam logic [7:0] IDX_PICTURE = 8'd2;
	localparam logic [7:0] IDX_DIP     = 8'd254;

	localparam int DL_ADDR_W     = 16;
	localparam int PIC_WORDS_DEF = 256;

	// ======================================================================
	// Pixel and picture word
	// ======================================================================
	typedef logic [23:0] rgb_t;

	typedef struct packed {
		logic [7:0] alpha;
		logic [7:0] blue;
		logic [7:0] green;
		logic [7:0] red;
	} pic_colour_t;

	// Loader fills byte lanes, fetcher reads colour fields
	typedef union packed {
		logic [3:0][7:0] lane;
		pic_colour_t     colour;
	} pic_word_u;

endpackage

//--- hw/download_loader.sv
/*
 * Decodes the host download stream into the game code, four DIP bytes and
 * picture memory writes issued over a four-phase request/acknowledge port.
 */
`timescale 1ns/1ps

module download_loader
	import arcade_pkg::*;
(
	input  logic                 clk_sys,
	input  logic                 rst_n,
	input  logic                 dl_wr,
	input  logic [7:0]           dl_index,
	input  logic [DL_ADDR_W-1:0] dl_addr,
	input  logic [7:0]           dl_data,
	input  logic                 wr_ack,
	output logic                 dl_wait,
	output logic [7:0]           game,
	output logic [7:0]           dip_a,
	output logic [7:0]           dip_b,
	output logic [7:0]           dip_c,
	output logic [7:0]           dip_d,
	output logic                 wr_req,
	output logic [DL_ADDR_W-3:0] wr_addr,
	output pic_word_u            wr_data,
	output logic                 pic_loaded
);

	logic dl_take;
	logic pic_take;
	logic pic_last;

	// A byte is taken only while no picture write is outstanding
	assign dl_take  = dl_wr & ~dl_wait;
	assign pic_take = dl_take && (dl_index == IDX_PICTURE);
	assign pic_last = pic_take && (dl_addr[1:0] == 2'd3);

	// ======================================================================
	// Game and DIP registers
	// ======================================================================
	always_ff @(posedge clk_sys or negedge rst_n)
	begin
		if (!rst_n)
		begin
			game       <= GAME_SCRAMBLE;
			dip_a      <= 8'hff;
			dip_b      <= 8'hff;
			dip_c      <= 8'hff;
			dip_d      <= 8'hff;
			pic_loaded <= 1'b0;
		end
		else if (dl_take)
		begin
			if (dl_index == IDX_GAME)
				game <= dl_data;
			if (dl_index == IDX_DIP && dl_addr < DL_ADDR_W'(4))
			begin
				case (dl_addr[1:0])
					2'd0: dip_a <= dl_data;
					2'd1: dip_b <= dl_data;
					2'd2: dip_c <= dl_data;
					default: dip_d <= dl_data;
				endcase
			end
			if (dl_index == IDX_PICTURE)
				pic_loaded <= 1'b1;
		end
	end

	// Word buffer, lane chosen by the low address bits
	always_ff @(posedge clk_sys)
	begin
		if (pic_take)
			wr_data.lane[dl_addr[1:0]] <= dl_data;
		if (pic_last)
			wr_addr <= dl_addr[DL_ADDR_W-1:2];
	end

	// ======================================================================
	// Write handshake
	// ======================================================================
	always_ff @(posedge clk_sys or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_req  <= 1'b0;
			dl_wait <= 1'b0;
		end
		else if (pic_last)
		begin
			wr_req  <= 1'b1;
			dl_wait <= 1'b1;
		end
		else if (wr_req && wr_ack)
			wr_req <= 1'b0;
		// Release the host once the arbiter has dropped its ack
		else if (dl_wait && !wr_req && !wr_ack)
			dl_wait <= 1'b0;
	end

endmodule

//--- hw/input_mapper.sv
/*
 * Merges both joysticks and builds the active-low player port bytes,
 * masked by the DIP bytes, plus the hardware select for the chosen game.
 */
`timescale 1ns/1ps

module input_mapper
	import arcade_pkg::*;
(
	input  logic             clk_sys,
	input  logic             rst_n,
	input  logic [JOY_W-1:0] joy1,
	input  logic [JOY_W-1:0] joy2,
	input  logic [7:0]       game,
	input  logic [7:0]       dip_a,
	input  logic [7:0]       dip_b,
	input  logic [7:0]       dip_c,
	input  logic [7:0]       dip_d,
	output logic [7:0]       port_a,
	output logic [7:0]       port_b,
	output logic [7:0]       port_c,
	output logic [7:0]       port_d,
	output logic [7:0]       hwsel,
	output logic             landscape
);

	logic [JOY_W-1:0] joy;
	logic             up;
	logic             down;
	logic             left;
	logic             right;
	logic             fire_a;
	logic             fire_b;
	logic             fire_c;
	logic             start1;
	logic             start2;
	logic             coin;
	logic [7:0]       map_a;
	logic [7:0]       map_b;
	logic [7:0]       map_c;
	logic [7:0]       map_hwsel;
	logic             map_land;

	// Either player can drive any control
	assign joy    = joy1 | joy2;
	assign up     = joy[JOY_UP];
	assign down   = joy[JOY_DOWN];
	assign left   = joy[JOY_LEFT];
	assign right  = joy[JOY_RIGHT];
	assign fire_a = joy[JOY_FIRE_A];
	assign fire_b = joy[JOY_FIRE_B];
	assign fire_c = joy[JOY_FIRE_C];
	assign start1 = joy[JOY_START1];
	assign start2 = joy[JOY_START2];
	assign coin   = joy[JOY_COIN];

	// ======================================================================
	// Per-game port layout, scramble wiring is the default
	// ======================================================================
	always_comb
	begin
		map_hwsel = 8'd0;
		map_land  = 1'b0;
		map_a     = ~{coin, 1'b0, left, right, fire_a, 1'b0, fire_b, up};
		map_b     = ~{start1, start2, left, right, fire_a, fire_b, 2'b00};
		map_c     = ~{1'b0, down, 1'b0, up, 3'b000, down};

		case (game)
			GAME_TAZMAN:
			begin
				map_hwsel = 8'd2;
				map_a     = ~{coin, 1'b0, left, right, down, up, fire_a, fire_b};
				map_b     = 8'hff;
				map_c     = ~{1'b0, start2, 5'b00000, start1};
			end
			GAME_SPDCOIN:
			begin
				map_hwsel = 8'd2;
				map_a     = ~{coin, 1'b0, left, right, start2, 1'b0, start1, 1'b0};
				map_b     = 8'hff;
				map_c     = 8'hff;
			end
			GAME_STRATGYX:
			begin
				map_hwsel = 8'd5;
				map_land  = 1'b1;
				// Fire C shows up on two bits of port C
				map_c     = ~{fire_c, down, fire_c, up, 3'b000, down};
			end
			default:
			begin
				map_hwsel = 8'd0;
			end
		endcase
	end

	always_ff @(posedge clk_sys or negedge rst_n)
	begin
		if (!rst_n)
		begin
			port_a    <= 8'hff;
			port_b    <= 8'hff;
			port_c    <= 8'hff;
			port_d    <= 8'hff;
			hwsel     <= 8'd0;
			landscape <= 1'b0;
		end
		else
		begin
			port_a    <= map_a & dip_a;
			port_b    <= map_b & dip_b;
			port_c    <= map_c & dip_c;
			// No control lands on port D in any game
			port_d    <= dip_d;
			hwsel     <= map_hwsel;
			landscape <= map_land;
		end
	end

endmodule

//--- hw/pic_arbiter.sv
/*
 * Owns the picture memory and serves the loader write port and the fetcher
 * read port, one four-phase transaction at a time with writes first.
 */
`timescale 1ns/1ps

module pic_arbiter
	import arcade_pkg::*;
#(
	parameter int PIC_WORDS = PIC_WORDS_DEF,
	localparam int PIC_AW = (PIC_WORDS > 1) ? $clog2(PIC_WORDS) : 1
)
(
	input  logic                 clk_sys,
	input  logic                 rst_n,
	input  logic                 wr_req,
	input  logic [DL_ADDR_W-3:0] wr_addr,
	input  pic_word_u            wr_data,
	input  logic                 rd_req,
	input  logic [PIC_AW-1:0]    rd_addr,
	output logic                 wr_ack,
	output logic                 rd_ack,
	output pic_word_u            rd_data
);

	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_WR   = 2'd1;
	localparam logic [1:0] ST_RD   = 2'd2;

	pic_word_u         pic_mem [PIC_WORDS];
	logic [1:0]        state;
	logic              wr_grant;
	logic              rd_grant;
	logic [PIC_AW-1:0] wr_index;

	// Write wins a tie
	assign wr_grant = (state == ST_IDLE) & wr_req;
	assign rd_grant = (state == ST_IDLE) & ~wr_req & rd_req;

	// Loader word address wraps on the memory depth
	assign wr_index = PIC_AW'(wr_addr % PIC_WORDS);

	always_ff @(posedge clk_sys)
	begin
		if (wr_grant)
			pic_mem[wr_index] <= wr_data;
		if (rd_grant)
			rd_data <= pic_mem[rd_addr];
	end

	// ======================================================================
	// Grant FSM
	// ======================================================================
	always_ff @(posedge clk_sys or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state  <= ST_IDLE;
			wr_ack <= 1'b0;
			rd_ack <= 1'b0;
		end
		else
		begin
			case (state)
				ST_IDLE:
				begin
					if (wr_grant)
					begin
						state  <= ST_WR;
						wr_ack <= 1'b1;
					end
					else if (rd_grant)
					begin
						state  <= ST_RD;
						rd_ack <= 1'b1;
					end
				end
				ST_WR:
				begin
					if (!wr_req)
					begin
						state  <= ST_IDLE;
						wr_ack <= 1'b0;
					end
				end
				ST_RD:
				begin
					// Read data stays put until the requester lets go
					if (!rd_req)
					begin
						state  <= ST_IDLE;
						rd_ack <= 1'b0;
					end
				end
				default:
				begin
					state  <= ST_IDLE;
					wr_ack <= 1'b0;
					rd_ack <= 1'b0;
				end
			endcase
		end
	end

endmodule

//--- hw/bg_fetcher.sv
/*
 * Walks the background picture in step with the video scan and places it
 * under the foreground pixel. Runs off its own pixel enable at clk_sys/4.
 */
`timescale 1ns/1ps

module bg_fetcher
	import arcade_pkg::*;
#(
	parameter int PIC_WORDS = PIC_WORDS_DEF,
	localparam int PIC_AW = (PIC_WORDS > 1) ? $clog2(PIC_WORDS) : 1
)
(
	input  logic              clk_sys,
	input  logic              rst_n,
	input  rgb_t              fg_rgb,
	input  logic              hblank,
	input  logic              vblank,
	input  logic              vsync,
	input  logic              flip,
	input  logic              pic_loaded,
	input  logic              rd_ack,
	input  pic_word_u         rd_data,
	output logic              rd_req,
	output logic [PIC_AW-1:0] rd_addr,
	output rgb_t              rgb_out
);

	localparam logic [PIC_AW-1:0] PIC_LAST = PIC_AW'(PIC_WORDS - 1);

	logic [1:0]        div;
	logic              ce_pix;
	logic              old_vs;
	logic              rd_busy;
	logic [PIC_AW-1:0] scan_addr;
	logic [PIC_AW-1:0] scan_next;
	pic_word_u         bg_word;
	pic_word_u         bg_eff;

	// ======================================================================
	// Pixel enable
	// ======================================================================
	always_ff @(posedge clk_sys or negedge rst_n)
	begin
		if (!rst_n)
		begin
			div    <= 2'd0;
			ce_pix <= 1'b0;
		end
		else
		begin
			div    <= div + 2'd1;
			ce_pix <= (div == 2'd3);
		end
	end

	// Next scan address, wrapping at both ends of the picture
	always_comb
	begin
		if (flip)
			scan_next = (scan_addr == '0) ? PIC_LAST : scan_addr - 1'b1;
		else
			scan_next = (scan_addr == PIC_LAST) ? '0 : scan_addr + 1'b1;
	end

	assign rd_busy = rd_req | rd_ack;

	// ======================================================================
	// Address scan and read handshake
	// ======================================================================
	always_ff @(posedge clk_sys or negedge rst_n)
	begin
		if (!rst_n)
		begin
			old_vs    <= 1'b0;
			scan_addr <= '0;
			rd_addr   <= '0;
			rd_req    <= 1'b0;
		end
		else
		begin
			if (rd_req && rd_ack)
				rd_req <= 1'b0;
			if (ce_pix)
			begin
				old_vs <= vsync;
				if (vsync && !old_vs)
					scan_addr <= flip ? PIC_LAST : '0;
				// A slow memory costs this pixel its address step
				else if (!(hblank || vblank) && !rd_busy)
				begin
					rd_addr   <= scan_addr;
					scan_addr <= scan_next;
					rd_req    <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk_sys)
	begin
		if (rd_req && rd_ack)
			bg_word <= rd_data;
	end

	// No picture yet means a fully transparent black background
	assign bg_eff = pic_loaded ? bg_word : '0;

	always_ff @(posedge clk_sys or negedge rst_n)
	begin
		if (!rst_n)
			rgb_out <= '0;
		else if (ce_pix)
		begin
			if ((fg_rgb != '0) && (bg_eff.colour.alpha == 8'd0))
				rgb_out <= fg_rgb;
			else
				rgb_out <= {bg_eff.colour.red, bg_eff.colour.green, bg_eff.colour.blue};
		end
	end

endmodule

//--- hw/arcade_shell.sv
/*
 * Board glue top level. Connects the download decoder, input mapper,
 * picture memory arbiter and background fetcher.
 */
`timescale 1ns/1ps

module arcade_shell
	import arcade_pkg::*;
#(
	parameter int PIC_WORDS = PIC_WORDS_DEF
)
(
	input  logic                 clk_sys,
	input  logic                 rst_n,
	input  logic                 dl_wr,
	input  logic [7:0]           dl_index,
	input  logic [DL_ADDR_W-1:0] dl_addr,
	input  logic [7:0]           dl_data,
	input  logic [JOY_W-1:0]     joy1,
	input  logic [JOY_W-1:0]     joy2,
	input  rgb_t                 fg_rgb,
	input  logic                 hblank,
	input  logic                 vblank,
	input  logic                 vsync,
	input  logic                 flip,
	output logic                 dl_wait,
	output logic [7:0]           port_a,
	output logic [7:0]           port_b,
	output logic [7:0]           port_c,
	output logic [7:0]           port_d,
	output logic [7:0]           hwsel,
	output logic                 landscape,
	output rgb_t                 rgb_out
);

	localparam int PIC_AW = (PIC_WORDS > 1) ? $clog2(PIC_WORDS) : 1;

	logic [7:0]           game;
	logic [7:0]           dip_a;
	logic [7:0]           dip_b;
	logic [7:0]           dip_c;
	logic [7:0]           dip_d;
	logic                 pic_loaded;
	logic                 wr_req;
	logic                 wr_ack;
	logic [DL_ADDR_W-3:0] wr_addr;
	pic_word_u            wr_data;
	logic                 rd_req;
	logic                 rd_ack;
	logic [PIC_AW-1:0]    rd_addr;
	pic_word_u            rd_data;

	download_loader u_loader (
		.clk_sys(clk_sys), .rst_n(rst_n),
		.dl_wr(dl_wr), .dl_index(dl_index), .dl_addr(dl_addr), .dl_data(dl_data),
		.wr_ack(wr_ack), .dl_wait(dl_wait), .game(game),
		.dip_a(dip_a), .dip_b(dip_b), .dip_c(dip_c), .dip_d(dip_d),
		.wr_req(wr_req), .wr_addr(wr_addr), .wr_data(wr_data), .pic_loaded(pic_loaded)
	);

	input_mapper u_inputs (
		.clk_sys(clk_sys), .rst_n(rst_n), .joy1(joy1), .joy2(joy2), .game(game),
		.dip_a(dip_a), .dip_b(dip_b), .dip_c(dip_c), .dip_d(dip_d),
		.port_a(port_a), .port_b(port_b), .port_c(port_c), .port_d(port_d),
		.hwsel(hwsel), .landscape(landscape)
	);

	// Picture memory shared by loader writes and fetcher reads
	pic_arbiter #(.PIC_WORDS(PIC_WORDS)) u_arbiter (
		.clk_sys(clk_sys), .rst_n(rst_n),
		.wr_req(wr_req), .wr_addr(wr_addr), .wr_data(wr_data),
		.rd_req(rd_req), .rd_addr(rd_addr),
		.wr_ack(wr_ack), .rd_ack(rd_ack), .rd_data(rd_data)
	);

	bg_fetcher #(.PIC_WORDS(PIC_WORDS)) u_fetcher (
		.clk_sys(clk_sys), .rst_n(rst_n), .fg_rgb(fg_rgb),
		.hblank(hblank), .vblank(vblank), .vsync(vsync), .flip(flip),
		.pic_loaded(pic_loaded), .rd_ack(rd_ack), .rd_data(rd_data),
		.rd_req(rd_req), .rd_addr(rd_addr), .rgb_out(rgb_out)
	);

endmodule

//--- test/arcade_assertions.sv
/*
 * Concurrent checks on the picture memory handshakes, bound into every
 * pic_arbiter instance.
 */
`timescale 1ns/1ps

module arcade_assertions (
	input logic clk_sys,
	input logic rst_n,
	input logic wr_req,
	input logic wr_ack,
	input logic rd_req,
	input logic rd_ack
);

	// ======================================================================
	// Ack follows its own request
	// ======================================================================
	wr_ack_has_req: assert property (@(posedge clk_sys) disable iff (!rst_n)
		$rose(wr_ack) |-> wr_req)
		else $error("wr_ack rose with wr_req low");

	rd_ack_has_req: assert property (@(posedge clk_sys) disable iff (!rst_n)
		$rose(rd_ack) |-> rd_req)
		else $error("rd_ack rose with rd_req low");

	// One transaction at a time
	acks_exclusive: assert property (@(posedge clk_sys) disable iff (!rst_n)
		!(wr_ack && rd_ack))
		else $error("wr_ack and rd_ack high together");

	wr_req_held: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(wr_req && !wr_ack) |=> wr_req)
		else $error("wr_req dropped before wr_ack");

	rd_req_held: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(rd_req && !rd_ack) |=> rd_req)
		else $error("rd_req dropped before rd_ack");

endmodule

bind pic_arbiter arcade_assertions u_handshake_check (
	.clk_sys(clk_sys),
	.rst_n(rst_n),
	.wr_req(wr_req),
	.wr_ack(wr_ack),
	.rd_req(rd_req),
	.rd_ack(rd_ack)
);

//--- test/tb_arcade_shell.sv
/*
 * Testbench for the arcade board glue. Applies a table of game rows with
 * LFSR joystick stimulus, then loads and scans background pictures.
 */
`timescale 1ns/1ps

module tb_arcade_shell
	import arcade_pkg::*;
();

	localparam int PIC_WORDS   = 16;
	localparam int NUM_ROWS    = 6;
	localparam int CYCLE_LIMIT = NUM_ROWS * 200 + 4 * PIC_WORDS * 40;

	typedef struct {
		string      name;
		logic       load_dip;
		logic [7:0] game;
		logic [7:0] a;
		logic [7:0] b;
		logic [7:0] c;
		logic [7:0] d;
		logic [7:0] hw;
		logic       land;
	} row_t;

	logic                 clk_sys;
	logic                 rst_n;
	logic                 dl_wr;
	logic [7:0]           dl_index;
	logic [DL_ADDR_W-1:0] dl_addr;
	logic [7:0]           dl_data;
	logic [JOY_W-1:0]     joy1;
	logic [JOY_W-1:0]     joy2;
	rgb_t                 fg_rgb;
	logic                 hblank;
	logic                 vblank;
	logic                 vsync;
	logic                 flip;
	logic                 dl_wait;
	logic [7:0]           port_a;
	logic [7:0]           port_b;
	logic [7:0]           port_c;
	logic [7:0]           port_d;
	logic [7:0]           hwsel;
	logic                 landscape;
	rgb_t                 rgb_out;

	row_t        rows [NUM_ROWS];
	logic [7:0]  dip_exp [4];
	logic [31:0] lfsr_state = 32'd75810;
	int          cycles     = 0;
	int          err_count  = 0;
	int          test_count = 0;
	int          test_fails = 0;

	arcade_shell #(.PIC_WORDS(PIC_WORDS)) DUT (
		.clk_sys(clk_sys), .rst_n(rst_n),
		.dl_wr(dl_wr), .dl_index(dl_index), .dl_addr(dl_addr), .dl_data(dl_data),
		.joy1(joy1), .joy2(joy2), .fg_rgb(fg_rgb),
		.hblank(hblank), .vblank(vblank), .vsync(vsync), .flip(flip),
		.dl_wait(dl_wait), .port_a(port_a), .port_b(port_b), .port_c(port_c),
		.port_d(port_d), .hwsel(hwsel), .landscape(landscape), .rgb_out(rgb_out)
	);

	always #50 clk_sys = ~clk_sys;

	// Run length guard
	always @(posedge clk_sys)
	begin
		cycles <= cycles + 1;
		if (cycles > CYCLE_LIMIT)
		begin
			$display("Timeout after %0d cycles, the tests did not complete", cycles);
			$display("Simulation FAILED");
			$finish;
		end
	end

	// ======================================================================
	// Stimulus helpers
	// ======================================================================
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {fb, s[31:1]};
	endfunction

	// One LFSR step per bit taken
	task automatic take_bits(input int n, output logic [31:0] v);
		int i;
		v = '0;
		for (i = 0; i < n; i++)
		begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
	endtask

	task automatic send_byte(input logic [7:0] idx, input logic [DL_ADDR_W-1:0] addr,
		input logic [7:0] data);
		@(negedge clk_sys);
		while (dl_wait)
			@(negedge clk_sys);
		dl_wr    = 1'b1;
		dl_index = idx;
		dl_addr  = addr;
		dl_data  = data;
		@(negedge clk_sys);
		dl_wr = 1'b0;
	endtask

	task automatic apply_joy(input logic [JOY_W-1:0] j1, input logic [JOY_W-1:0] j2);
		@(negedge clk_sys);
		joy1 = j1;
		joy2 = j2;
		@(negedge clk_sys);
	endtask

	// Port layouts per game, result is {landscape, hwsel, A, B, C, D}
	function automatic logic [40:0] model_ports(input logic [7:0] g, input logic [JOY_W-1:0] j);
		logic [7:0] a;
		logic [7:0] b;
		logic [7:0] c;
		logic [7:0] hw;
		logic       land;
		a    = ~{j[JOY_COIN], 1'b0, j[JOY_LEFT], j[JOY_RIGHT], j[JOY_FIRE_A], 1'b0,
			j[JOY_FIRE_B], j[JOY_UP]};
		b    = ~{j[JOY_START1], j[JOY_START2], j[JOY_LEFT], j[JOY_RIGHT], j[JOY_FIRE_A],
			j[JOY_FIRE_B], 2'b00};
		c    = ~{1'b0, j[JOY_DOWN], 1'b0, j[JOY_UP], 3'b000, j[JOY_DOWN]};
		hw   = 8'd0;
		land = 1'b0;
		if (g == GAME_TAZMAN)
		begin
			a  = ~{j[JOY_COIN], 1'b0, j[JOY_LEFT], j[JOY_RIGHT], j[JOY_DOWN], j[JOY_UP],
				j[JOY_FIRE_A], j[JOY_FIRE_B]};
			b  = 8'hff;
			c  = ~{1'b0, j[JOY_START2], 5'b00000, j[JOY_START1]};
			hw = 8'd2;
		end
		else if (g == GAME_SPDCOIN)
		begin
			a  = ~{j[JOY_COIN], 1'b0, j[JOY_LEFT], j[JOY_RIGHT], j[JOY_START2], 1'b0,
				j[JOY_START1], 1'b0};
			b  = 8'hff;
			c  = 8'hff;
			hw = 8'd2;
		end
		else if (g == GAME_STRATGYX)
		begin
			c    = ~{j[JOY_FIRE_C], j[JOY_DOWN], j[JOY_FIRE_C], j[JOY_UP], 3'b000, j[JOY_DOWN]};
			hw   = 8'd5;
			land = 1'b1;
		end
		return {land, hw, a, b, c, 8'hff};
	endfunction

	// ======================================================================
	// Checking helpers
	// ======================================================================
	task automatic check_value(input string test, input string what, input logic [31:0] exp,
		input logic [31:0] act);
		if (act !== exp)
		begin
			$display("CHECK FAILED %s %s expected %0h actual %0h", test, what, exp, act);
			err_count++;
		end
	endtask

	task automatic check_ports(input string test, input logic [40:0] exp);
		check_value(test, "port_a", 32'(exp[31:24] & dip_exp[0]), 32'(port_a));
		check_value(test, "port_b", 32'(exp[23:16] & dip_exp[1]), 32'(port_b));
		check_value(test, "port_c", 32'(exp[15:8] & dip_exp[2]), 32'(port_c));
		check_value(test, "port_d", 32'(exp[7:0] & dip_exp[3]), 32'(port_d));
		check_value(test, "hwsel", 32'(exp[39:32]), 32'(hwsel));
		check_value(test, "landscape", 32'(exp[40]), 32'(landscape));
	endtask

	task automatic finish_test(input string test, input int errs_before);
		test_count++;
		if (err_count == errs_before)
			$display("test %s: ok", test);
		else
		begin
			test_fails++;
			$display("test %s: %0d checks failed", test, err_count - errs_before);
		end
	endtask

	// Controls all pressed, split over both joysticks
	task automatic load_table();
		rows[0] = '{"scramble", 1'b0, GAME_SCRAMBLE, 8'h44, 8'h03, 8'hae, 8'hff, 8'd0, 1'b0};
		rows[1] = '{"tazman", 1'b0, GAME_TAZMAN, 8'h40, 8'hff, 8'hbe, 8'hff, 8'd2, 1'b0};
		rows[2] = '{"spdcoin", 1'b0, GAME_SPDCOIN, 8'h45, 8'hff, 8'hff, 8'hff, 8'd2, 1'b0};
		rows[3] = '{"stratgyx", 1'b0, GAME_STRATGYX, 8'h44, 8'h03, 8'h0e, 8'hff, 8'd5, 1'b1};
		rows[4] = '{"unknown", 1'b0, 8'd9, 8'h44, 8'h03, 8'hae, 8'hff, 8'd0, 1'b0};
		rows[5] = '{"dip_mask", 1'b1, GAME_STRATGYX, 8'h44, 8'h03, 8'h0e, 8'hff, 8'd5, 1'b1};
	endtask

	// ======================================================================
	// Tests
	// ======================================================================
	task automatic run_row(input int r);
		logic [31:0] v1;
		logic [31:0] v2;
		int          errs_before;
		int          k;
		errs_before = err_count;
		if (rows[r].load_dip)
		begin
			for (k = 0; k < 4; k++)
			begin
				take_bits(8, v1);
				dip_exp[k] = v1[7:0];
				send_byte(IDX_DIP, DL_ADDR_W'(k), dip_exp[k]);
			end
		end
		send_byte(IDX_GAME, '0, rows[r].game);
		apply_joy(12'h50f, 12'h270);
		check_ports(rows[r].name, {rows[r].land, rows[r].hw, rows[r].a, rows[r].b,
			rows[r].c, rows[r].d});
		for (k = 0; k < 10; k++)
		begin
			take_bits(JOY_W, v1);
			take_bits(JOY_W, v2);
			apply_joy(v1[JOY_W-1:0], v2[JOY_W-1:0]);
			check_ports(rows[r].name, model_ports(rows[r].game, v1[JOY_W-1:0] | v2[JOY_W-1:0]));
		end
		finish_test(rows[r].name, errs_before);
	endtask

	// Alpha carries the word index when opaque
	task automatic load_picture(input int base, input rgb_t colour, input logic opaque);
		int w;
		for (w = 0; w < PIC_WORDS; w++)
		begin
			send_byte(IDX_PICTURE, DL_ADDR_W'(base + 4 * w), colour[23:16]);
			send_byte(IDX_PICTURE, DL_ADDR_W'(base + 4 * w + 1), colour[15:8]);
			send_byte(IDX_PICTURE, DL_ADDR_W'(base + 4 * w + 2), colour[7:0]);
			send_byte(IDX_PICTURE, DL_ADDR_W'(base + 4 * w + 3), opaque ? 8'h80 | 8'(w) : 8'h00);
		end
		while (dl_wait)
			@(negedge clk_sys);
	endtask

	task automatic scan_check(input string test, input rgb_t bg, input logic see_through);
		logic [31:0] v;
		rgb_t        exp;
		int          errs_before;
		int          k;
		errs_before = err_count;
		@(negedge clk_sys);
		vsync = 1'b1;
		repeat (8) @(negedge clk_sys);
		vsync = 1'b0;
		repeat (4) @(negedge clk_sys);
		hblank = 1'b0;
		vblank = 1'b0;
		repeat (16) @(negedge clk_sys);
		for (k = 0; k < 12; k++)
		begin
			take_bits(24, v);
			fg_rgb = (k % 3 == 0) ? '0 : v[23:0];
			repeat (8) @(negedge clk_sys);
			exp = (see_through && fg_rgb != '0) ? fg_rgb : bg;
			check_value(test, "rgb_out", 32'(exp), 32'(rgb_out));
		end
		hblank = 1'b1;
		vblank = 1'b1;
		finish_test(test, errs_before);
	endtask

	initial
	begin
		int errs_before;
		int r;
		clk_sys  = 1'b0;
		rst_n    = 1'b0;
		dl_wr    = 1'b0;
		dl_index = '0;
		dl_addr  = '0;
		dl_data  = '0;
		joy1     = '0;
		joy2     = '0;
		fg_rgb   = '0;
		hblank   = 1'b1;
		vblank   = 1'b1;
		vsync    = 1'b0;
		flip     = 1'b0;
		for (r = 0; r < 4; r++)
			dip_exp[r] = 8'hff;
		load_table();
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		rst_n = 1'b1;

		errs_before = err_count;
		check_ports("reset", {1'b0, 8'd0, 32'hffffffff});
		check_value("reset", "dl_wait", 32'd0, 32'(dl_wait));
		check_value("reset", "rgb_out", 32'd0, 32'(rgb_out));
		finish_test("reset", errs_before);

		for (r = 0; r < NUM_ROWS; r++)
			run_row(r);

		// Visible scan with no picture downloaded yet
		errs_before = err_count;
		@(negedge clk_sys);
		hblank = 1'b0;
		vblank = 1'b0;
		fg_rgb = 24'h1f2e3d;
		repeat (8) @(negedge clk_sys);
		check_value("no_picture", "rgb_out", 32'h1f2e3d, 32'(rgb_out));
		hblank = 1'b1;
		vblank = 1'b1;
		finish_test("no_picture", errs_before);

		load_picture(0, 24'h3c5a96, 1'b1);
		scan_check("opaque", 24'h3c5a96, 1'b0);

		// Byte addresses one picture up wrap onto the same words
		flip = 1'b1;
		load_picture(4 * PIC_WORDS, 24'hc36917, 1'b0);
		scan_check("transparent", 24'hc36917, 1'b1);

		$display("tests %0d, tests failed %0d, checks failed %0d", test_count, test_fails,
			err_count);
		if (err_count == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

//--- tb.f
hw/arcade_pkg.sv
hw/download_loader.sv
hw/input_mapper.sv
hw/pic_arbiter.sv
hw/bg_fetcher.sv
hw/arcade_shell.sv
test/arcade_assertions.sv
test/tb_arcade_shell.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the arcade shell testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_arcade_shell -f tb.f -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -qx "Simulation PASSED" sim.log; then
	exit 0
fi
exit 1
